/* c7bexu.f */
+incdir+.
c7bexu_pkg.sv
c7bexu_rf.sv
c7bexu_byp.sv
c7bexu_alu.sv
c7bexu_bru.sv
c7bexu.sv
c7bexu_chk.sv
tb_c7bexu.sv

/* tb_c7bexu.sv */
`include "c7bexu_consts.svh"

module tb_c7bexu;

   import c7bexu_pkg::*;

   // one issue slot and what it should produce three cycles later
   typedef struct packed {
      issue_s                   iss;
      logic                     cvld;
      logic [`C7B_REG_BITS-1:0] crd;
      logic [`C7B_XLEN-1:0]     cdata;
      logic                     br;
      logic [`C7B_XLEN-1:0]     baddr;
   } row_s;

   logic                 clk = 1'b0;
   logic                 rst;
   issue_s               issue;
   commit_s              commit;
   logic                 exu_ifu_branch;
   logic [`C7B_XLEN-1:0] exu_ifu_brn_addr;

   row_s rows[$];
   int   squash_left = 0;
   int   errors = 0;
   int   cycles = 0;
   int   limit = 0;
   int   cur_row = 0;
   int   afails;

   c7bexu c7bexu_i (
      .clk              (clk),
      .rst              (rst),
      .issue            (issue),
      .commit           (commit),
      .exu_ifu_branch   (exu_ifu_branch),
      .exu_ifu_brn_addr (exu_ifu_brn_addr)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles >= limit) begin
         $display("timeout: run hung after %0d cycles with %0d errors", cycles, errors);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   task automatic compare(input string name, input logic [`C7B_XLEN-1:0] got,
                          input logic [`C7B_XLEN-1:0] exp);
      if (got !== exp) begin
         $display("FAILED %s (row %0d): got %h, expected %h", name, cur_row, got, exp);
         errors++;
      end
   endtask

   // random fill for the fields a slot does not use
   // pc steps by one instruction per row
   function automatic issue_s base_issue(input int unsigned idx);
      issue_s      s;
      logic [31:0] r;
      r        = $urandom;
      s.vld    = 1'b1;
      s.pc     = 32'h1000 + idx * 4;
      s.rs1    = r[4:0];
      s.rs2    = r[9:5];
      s.rd     = r[14:10];
      s.wen    = 1'b1;
      s.imm    = $urandom;
      s.unit   = r[15];
      s.op     = r[19:16];
      s.a_pc   = r[20];
      s.b_imm  = r[21];
      s.offset = $urandom;
      return s;
   endfunction

   // three slots behind a taken branch never commit or branch
   task automatic push_row(input row_s r);
      row_s s;
      s = r;
      if (squash_left > 0) begin
         s.cvld = 1'b0;
         s.br   = 1'b0;
         squash_left--;
      end else if (s.br) begin
         squash_left = 3;
      end
      rows.push_back(s);
   endtask

   // a negative rs1 selects pc as a, a negative rs2 selects imm as b
   task automatic alu_row(input alu_op_e op, input int rd, input int rs1, input int rs2,
                          input logic [`C7B_XLEN-1:0] imm, input logic [`C7B_XLEN-1:0] res);
      row_s r;
      r.iss        = base_issue(rows.size());
      r.iss.unit   = 1'b0;
      r.iss.op.alu = op;
      r.iss.rd     = rd[4:0];
      r.iss.a_pc   = (rs1 < 0);
      r.iss.b_imm  = (rs2 < 0);
      r.iss.rs1    = (rs1 < 0) ? r.iss.rs1 : rs1[4:0];
      r.iss.rs2    = (rs2 < 0) ? r.iss.rs2 : rs2[4:0];
      r.iss.imm    = (rs2 < 0) ? imm : r.iss.imm;
      r.cvld       = (rd != 0);
      r.crd        = rd[4:0];
      r.cdata      = res;
      r.br         = 1'b0;
      r.baddr      = '0;
      push_row(r);
   endtask

   // tgt is the redirect address expected when the branch is taken
   task automatic bru_row(input bru_op_e op, input int rd, input int rs1, input int rs2,
                          input logic [`C7B_XLEN-1:0] off, input logic taken,
                          input logic [`C7B_XLEN-1:0] tgt);
      row_s r;
      r.iss        = base_issue(rows.size());
      r.iss.unit   = 1'b1;
      r.iss.op.bru = op;
      r.iss.rd     = rd[4:0];
      r.iss.rs1    = rs1[4:0];
      r.iss.rs2    = rs2[4:0];
      r.iss.offset = off;
      r.cvld       = (op == bru_bl || op == bru_jirl) && rd != 0;
      r.crd        = rd[4:0];
      r.cdata      = r.iss.pc + `C7B_INSN_BYTES;
      r.br         = taken;
      r.baddr      = tgt;
      push_row(r);
   endtask

   task automatic idle_row();
      row_s r;
      r.iss     = base_issue(rows.size());
      r.iss.vld = 1'b0;
      r.cvld    = 1'b0;
      r.crd     = '0;
      r.cdata   = '0;
      r.br      = 1'b0;
      r.baddr   = '0;
      push_row(r);
   endtask

   task automatic fill_table();
      alu_row(alu_lui, 1, -1, -1, 32'h12345000, 32'h12345000);
      alu_row(alu_add, 2, 1, -1, 32'h00000678, 32'h12345678);
      alu_row(alu_add, 3, -1, -1, 32'h00000010, 32'h00001018);
      alu_row(alu_sub, 4, 2, 1, '0, 32'h00000678);
      alu_row(alu_lui, 5, -1, -1, 32'hfffff000, 32'hfffff000);
      alu_row(alu_slt, 6, 5, 4, '0, 32'h00000001);
      alu_row(alu_sltu, 7, 5, 4, '0, 32'h00000000);
      alu_row(alu_and, 8, 2, -1, 32'h0000ff0f, 32'h00005608);
      alu_row(alu_or, 9, 1, 4, '0, 32'h12345678);
      alu_row(alu_xor, 10, 9, -1, 32'hffffffff, 32'hedcba987);
      alu_row(alu_nor, 11, 10, 4, '0, 32'h12345000);
      alu_row(alu_sll, 12, 4, -1, 32'h00000024, 32'h00006780);
      alu_row(alu_srl, 13, 5, -1, 32'h00000008, 32'h00fffff0);
      alu_row(alu_sra, 14, 5, 13, '0, 32'hffffffff);
      // r0 as destination, then as source
      alu_row(alu_add, 0, 1, -1, 32'h00000005, 32'h12345005);
      alu_row(alu_add, 15, 0, -1, 32'h00000077, 32'h00000077);
      idle_row();
      alu_row(alu_or, 16, 0, 15, '0, 32'h00000077);
      bru_row(bru_bltu, 9, 5, 4, 32'h00000100, 1'b0, 32'h00001148);
      alu_row(alu_add, 17, 16, -1, 32'h00000001, 32'h00000078);
      bru_row(bru_bne, 0, 17, 16, 32'h00000100, 1'b1, 32'h00001150);
      alu_row(alu_add, 1, 0, -1, 32'h00000099, 32'h00000099);
      bru_row(bru_b, 0, 0, 0, 32'h00000040, 1'b1, 32'h00001098);
      alu_row(alu_add, 18, 0, -1, 32'h00000001, 32'h00000001);
      // r1 must still hold its value from before the flush
      alu_row(alu_add, 20, 1, -1, '0, 32'h12345000);
      bru_row(bru_bl, 21, 0, 0, 32'h00000400, 1'b1, 32'h00001464);
      alu_row(alu_add, 22, 0, -1, 32'h00000002, 32'h00000002);
      idle_row();
      alu_row(alu_add, 23, 0, -1, 32'h00000003, 32'h00000003);
      bru_row(bru_jirl, 23, 21, 0, 32'h00000010, 1'b1, 32'h00001078);
      alu_row(alu_add, 24, 0, -1, 32'h00000004, 32'h00000004);
      bru_row(bru_beq, 0, 0, 0, 32'h00000008, 1'b1, 32'h00001084);
      alu_row(alu_add, 25, 0, -1, 32'h00000005, 32'h00000005);
      bru_row(bru_blt, 0, 5, 4, 32'hffffffc0, 1'b1, 32'h00001044);
      bru_row(bru_bl, 24, 0, 0, 32'h00000020, 1'b1, 32'h000010a8);
      alu_row(alu_add, 26, 0, -1, 32'h00000006, 32'h00000006);
      idle_row();
      alu_row(alu_add, 24, 23, -1, 32'h00000004, 32'h0000107c);
      bru_row(bru_bl, 0, 0, 0, 32'h00000040, 1'b1, 32'h000010d8);
      idle_row();
      idle_row();
      idle_row();
      // with two writes to r26 in flight the m-stage value wins
      alu_row(alu_add, 26, 0, -1, 32'h00000001, 32'h00000001);
      alu_row(alu_add, 26, 0, -1, 32'h00000002, 32'h00000002);
      alu_row(alu_add, 27, 26, -1, '0, 32'h00000002);
   endtask

   task automatic check_row(input int i);
      cur_row = i;
      compare("commit.vld", 32'(commit.vld), 32'(rows[i].cvld));
      if (rows[i].cvld) begin
         compare("commit.rd", 32'(commit.rd), 32'(rows[i].crd));
         compare("commit.pc", commit.pc, rows[i].iss.pc);
         compare("commit.data", commit.data, rows[i].cdata);
      end
      compare("exu_ifu_branch", 32'(exu_ifu_branch), 32'(rows[i].br));
      if (rows[i].br) begin
         compare("exu_ifu_brn_addr", exu_ifu_brn_addr, rows[i].baddr);
      end
   endtask

   initial begin
      void'($urandom(50));
      fill_table();
      limit = rows.size() + 16 + `C7B_TIMEOUT_MARGIN;
      issue = '0;
      rst   = 1'b1;
      repeat (16) @(posedge clk);
      #1 rst = 1'b0;
      // row j is checked three edges after it was driven
      for (int j = 0; j < rows.size() + 3; j++) begin
         @(posedge clk);
         #1;
         if (j >= 3) begin
            check_row(j - 3);
         end
         issue = (j < rows.size()) ? rows[j].iss : '0;
      end
      afails = c7bexu_i.c7bexu_chk_i.fails;
      $display("%0d rows, %0d check errors, %0d assertion failures",
               rows.size(), errors, afails);
      if (errors == 0 && afails == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

/* c7bexu_chk.sv */
module c7bexu_chk (
   input logic                clk,
   input logic                rst,
   input c7bexu_pkg::commit_s commit,
   input logic                exu_ifu_branch
);

   // assertion failures seen so far
   int fails = 0;

   // nothing retires or redirects right after a reset edge
   idle_after_rst: assert property (@(posedge clk) rst |=> !commit.vld && !exu_ifu_branch)
      else begin
         $error("commit or redirect active in the cycle after reset");
         fails++;
      end

   // redirect is a single-cycle pulse
   branch_pulse: assert property (@(posedge clk) disable iff (rst)
      exu_ifu_branch |=> !exu_ifu_branch)
      else begin
         $error("exu_ifu_branch held high for two cycles");
         fails++;
      end

   // r0 is never a retirement target
   commit_rd_nonzero: assert property (@(posedge clk) disable iff (rst)
      commit.vld |-> commit.rd != '0)
      else begin
         $error("commit with register 0 as destination");
         fails++;
      end

endmodule

bind c7bexu c7bexu_chk c7bexu_chk_i (
   .clk            (clk),
   .rst            (rst),
   .commit         (commit),
   .exu_ifu_branch (exu_ifu_branch)
);

/* c7bexu.sv */
`include "c7bexu_consts.svh"

module c7bexu (
   input  logic                 clk,
   input  logic                 rst,

   // decode-stage issue
   input  c7bexu_pkg::issue_s   issue,

   // w-stage retirement
   output c7bexu_pkg::commit_s  commit,

   // redirect to fetch
   output logic                 exu_ifu_branch,
   output logic [`C7B_XLEN-1:0] exu_ifu_brn_addr
);

   import c7bexu_pkg::*;

   // e stage
   issue_s               ex_q;
   logic [`C7B_XLEN-1:0] rs1_data_d;
   logic [`C7B_XLEN-1:0] rs2_data_d;
   logic [`C7B_XLEN-1:0] rs1_data_e;
   logic [`C7B_XLEN-1:0] rs2_data_e;
   logic [`C7B_XLEN-1:0] rs1_data_byp_e;
   logic [`C7B_XLEN-1:0] rs2_data_byp_e;
   logic [`C7B_XLEN-1:0] alu_a_e;
   logic [`C7B_XLEN-1:0] alu_b_e;
   logic [`C7B_XLEN-1:0] alu_res_e;
   logic                 bru_vld_e;
   logic                 bru_taken_e;
   logic [`C7B_XLEN-1:0] bru_target_e;
   logic [`C7B_XLEN-1:0] bru_link_pc_e;
   logic                 is_link_e;
   logic [`C7B_XLEN-1:0] res_e;

   // m and w stages, vld here means the instruction writes rd
   commit_s              m_q;
   commit_s              w_q;
   logic                 br_m;
   logic                 br_w;
   logic [`C7B_XLEN-1:0] brn_addr_m;
   logic [`C7B_XLEN-1:0] brn_addr_w;

   logic                 flush;
   logic                 issue_ok;

   // a taken branch anywhere in e, m or w kills the three slots behind it
   assign flush    = bru_taken_e | br_m | br_w;
   assign issue_ok = issue.vld & ~flush;

   c7bexu_rf u_rf (
      .clk    (clk),
      .raddr0 (issue.rs1),
      .raddr1 (issue.rs2),
      .rdata0 (rs1_data_d),
      .rdata1 (rs2_data_d),
      .wen    (w_q.vld),
      .waddr  (w_q.rd),
      .wdata  (w_q.data)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         ex_q.vld <= 1'b0;
         ex_q.wen <= 1'b0;
      end else begin
         ex_q     <= issue;
         ex_q.vld <= issue_ok;
         // r0 destinations never write
         ex_q.wen <= issue_ok & issue.wen & (issue.rd != '0);
      end
   end

   // operands read in decode, forwarded in e
   always_ff @(posedge clk) begin
      rs1_data_e <= rs1_data_d;
      rs2_data_e <= rs2_data_d;
   end

   c7bexu_byp u_byp (
      .rs1_e          (ex_q.rs1),
      .rs2_e          (ex_q.rs2),
      .rs1_data_e     (rs1_data_e),
      .rs2_data_e     (rs2_data_e),
      .rd_m           (m_q.rd),
      .wen_m          (m_q.vld),
      .rd_data_m      (m_q.data),
      .rd_w           (w_q.rd),
      .wen_w          (w_q.vld),
      .rd_data_w      (w_q.data),
      .rs1_data_byp_e (rs1_data_byp_e),
      .rs2_data_byp_e (rs2_data_byp_e)
   );

   assign alu_a_e = ex_q.a_pc  ? ex_q.pc  : rs1_data_byp_e;
   assign alu_b_e = ex_q.b_imm ? ex_q.imm : rs2_data_byp_e;

   c7bexu_alu u_alu (
      .a      (alu_a_e),
      .b      (alu_b_e),
      .op     (ex_q.op.alu),
      .result (alu_res_e)
   );

   assign bru_vld_e = ex_q.vld & ex_q.unit;

   c7bexu_bru u_bru (
      .vld     (bru_vld_e),
      .op      (ex_q.op.bru),
      .a       (rs1_data_byp_e),
      .b       (rs2_data_byp_e),
      .pc      (ex_q.pc),
      .offset  (ex_q.offset),
      .taken   (bru_taken_e),
      .target  (bru_target_e),
      .link_pc (bru_link_pc_e)
   );

   // only bl and jirl leave a link behind
   assign is_link_e = ex_q.unit & (ex_q.op.bru == bru_bl || ex_q.op.bru == bru_jirl);
   assign res_e     = ex_q.unit ? bru_link_pc_e : alu_res_e;

   always_ff @(posedge clk) begin
      if (rst) begin
         m_q.vld <= 1'b0;
         w_q.vld <= 1'b0;
         br_m    <= 1'b0;
         br_w    <= 1'b0;
      end else begin
         m_q.vld    <= ex_q.wen & (~ex_q.unit | is_link_e);
         m_q.pc     <= ex_q.pc;
         m_q.rd     <= ex_q.rd;
         m_q.data   <= res_e;
         w_q        <= m_q;
         br_m       <= bru_taken_e;
         br_w       <= br_m;
         brn_addr_m <= bru_target_e;
         brn_addr_w <= brn_addr_m;
      end
   end

   assign commit = w_q;

   // redirect leaves from w, a single cycle wide
   assign exu_ifu_branch   = br_w;
   assign exu_ifu_brn_addr = brn_addr_w;

endmodule

/* c7bexu_bru.sv */
`include "c7bexu_consts.svh"

module c7bexu_bru (
   input  logic                 vld,
   input  c7bexu_pkg::bru_op_e  op,
   input  logic [`C7B_XLEN-1:0] a,
   input  logic [`C7B_XLEN-1:0] b,
   input  logic [`C7B_XLEN-1:0] pc,
   input  logic [`C7B_XLEN-1:0] offset,
   output logic                 taken,
   output logic [`C7B_XLEN-1:0] target,
   output logic [`C7B_XLEN-1:0] link_pc
);

   import c7bexu_pkg::*;

   logic cond;

   always_comb begin
      case (op)
         bru_beq: begin
            cond = a == b;
         end
         bru_bne: begin
            cond = a != b;
         end
         bru_blt: begin
            cond = $signed(a) < $signed(b);
         end
         bru_bge: begin
            cond = $signed(a) >= $signed(b);
         end
         bru_bltu: begin
            cond = a < b;
         end
         bru_bgeu: begin
            cond = a >= b;
         end
         // unconditional forms
         bru_b, bru_bl, bru_jirl: begin
            cond = 1'b1;
         end
         default: begin
            cond = 1'b0;
         end
      endcase
   end

   assign taken = vld & cond;

   // jirl is register relative, the rest pc relative
   assign target = (op == bru_jirl) ? a + offset : pc + offset;

   assign link_pc = pc + `C7B_INSN_BYTES;

endmodule

/* c7bexu_alu.sv */
`include "c7bexu_consts.svh"

module c7bexu_alu (
   input  logic [`C7B_XLEN-1:0] a,
   input  logic [`C7B_XLEN-1:0] b,
   input  c7bexu_pkg::alu_op_e  op,
   output logic [`C7B_XLEN-1:0] result
);

   import c7bexu_pkg::*;

   logic [$clog2(`C7B_XLEN)-1:0] shamt;
   logic                         lt_s;
   logic                         lt_u;

   // shifts only look at the low bits of b
   assign shamt = b[$clog2(`C7B_XLEN)-1:0];

   assign lt_s = $signed(a) < $signed(b);
   assign lt_u = a < b;

   always_comb begin
      case (op)
         alu_add: begin
            result = a + b;
         end
         alu_sub: begin
            result = a - b;
         end
         alu_slt: begin
            result = {{(`C7B_XLEN-1){1'b0}}, lt_s};
         end
         alu_sltu: begin
            result = {{(`C7B_XLEN-1){1'b0}}, lt_u};
         end
         alu_and: begin
            result = a & b;
         end
         alu_or: begin
            result = a | b;
         end
         alu_xor: begin
            result = a ^ b;
         end
         alu_nor: begin
            result = ~(a | b);
         end
         alu_sll: begin
            result = a << shamt;
         end
         alu_srl: begin
            result = a >> shamt;
         end
         alu_sra: begin
            result = $signed(a) >>> shamt;
         end
         // immediate is already shifted by decode
         alu_lui: begin
            result = b;
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

/* c7bexu_byp.sv */
`include "c7bexu_consts.svh"

module c7bexu_byp (
   input  logic [`C7B_REG_BITS-1:0] rs1_e,
   input  logic [`C7B_REG_BITS-1:0] rs2_e,
   input  logic [`C7B_XLEN-1:0]     rs1_data_e,
   input  logic [`C7B_XLEN-1:0]     rs2_data_e,
   input  logic [`C7B_REG_BITS-1:0] rd_m,
   input  logic                     wen_m,
   input  logic [`C7B_XLEN-1:0]     rd_data_m,
   input  logic [`C7B_REG_BITS-1:0] rd_w,
   input  logic                     wen_w,
   input  logic [`C7B_XLEN-1:0]     rd_data_w,
   output logic [`C7B_XLEN-1:0]     rs1_data_byp_e,
   output logic [`C7B_XLEN-1:0]     rs2_data_byp_e
);

   logic rs1_hit_m;
   logic rs1_hit_w;
   logic rs2_hit_m;
   logic rs2_hit_w;

   // a hit needs a pending write to the same register, never r0
   assign rs1_hit_m = wen_m && rd_m == rs1_e && rs1_e != '0;
   assign rs1_hit_w = wen_w && rd_w == rs1_e && rs1_e != '0;
   assign rs2_hit_m = wen_m && rd_m == rs2_e && rs2_e != '0;
   assign rs2_hit_w = wen_w && rd_w == rs2_e && rs2_e != '0;

   // youngest producer first
   assign rs1_data_byp_e = rs1_hit_m ? rd_data_m :
                           rs1_hit_w ? rd_data_w : rs1_data_e;
   assign rs2_data_byp_e = rs2_hit_m ? rd_data_m :
                           rs2_hit_w ? rd_data_w : rs2_data_e;

endmodule

/* c7bexu_rf.sv */
`include "c7bexu_consts.svh"

module c7bexu_rf (
   input  logic                     clk,
   input  logic [`C7B_REG_BITS-1:0] raddr0,
   input  logic [`C7B_REG_BITS-1:0] raddr1,
   output logic [`C7B_XLEN-1:0]     rdata0,
   output logic [`C7B_XLEN-1:0]     rdata1,
   input  logic                     wen,
   input  logic [`C7B_REG_BITS-1:0] waddr,
   input  logic [`C7B_XLEN-1:0]     wdata
);

   logic [`C7B_XLEN-1:0] regs [`C7B_NREGS];

   // r0 is hardwired, a same-cycle write wins over the stored word
   function automatic logic [`C7B_XLEN-1:0] read_port(
      input logic [`C7B_REG_BITS-1:0] addr,
      input logic [`C7B_XLEN-1:0]     stored,
      input logic                     we,
      input logic [`C7B_REG_BITS-1:0] wa,
      input logic [`C7B_XLEN-1:0]     wd
   );
      if (addr == '0) begin
         return '0;
      end
      if (we && wa == addr) begin
         return wd;
      end
      return stored;
   endfunction

   // writes to r0 are dropped
   always_ff @(posedge clk) begin
      if (wen && waddr != '0) begin
         regs[waddr] <= wdata;
      end
   end

   assign rdata0 = read_port(raddr0, regs[raddr0], wen, waddr, wdata);
   assign rdata1 = read_port(raddr1, regs[raddr1], wen, waddr, wdata);

endmodule

/* c7bexu_pkg.sv */
`include "c7bexu_consts.svh"

package c7bexu_pkg;

   // alu operations, lui passes b through
   typedef enum logic [`C7B_OP_BITS-1:0] {
      alu_add,
      alu_sub,
      alu_slt,
      alu_sltu,
      alu_and,
      alu_or,
      alu_xor,
      alu_nor,
      alu_sll,
      alu_srl,
      alu_sra,
      alu_lui
   } alu_op_e;

   // branch operations
   typedef enum logic [`C7B_OP_BITS-1:0] {
      bru_beq,
      bru_bne,
      bru_blt,
      bru_bge,
      bru_bltu,
      bru_bgeu,
      bru_b,
      bru_bl,
      bru_jirl
   } bru_op_e;

   // one op field, read by whichever unit the instruction goes to
   typedef union packed {
      alu_op_e alu;
      bru_op_e bru;
   } op_word_u;

   typedef struct packed {
      logic                     vld;
      logic [`C7B_XLEN-1:0]     pc;
      logic [`C7B_REG_BITS-1:0] rs1;
      logic [`C7B_REG_BITS-1:0] rs2;
      logic [`C7B_REG_BITS-1:0] rd;
      logic                     wen;
      logic [`C7B_XLEN-1:0]     imm;
      // 1 selects the branch unit
      logic                     unit;
      op_word_u                 op;
      logic                     a_pc;
      logic                     b_imm;
      logic [`C7B_XLEN-1:0]     offset;
   } issue_s;

   // retirement as seen from the w stage
   typedef struct packed {
      logic                     vld;
      logic [`C7B_XLEN-1:0]     pc;
      logic [`C7B_REG_BITS-1:0] rd;
      logic [`C7B_XLEN-1:0]     data;
   } commit_s;

endpackage

/* c7bexu_consts.svh */
`ifndef C7BEXU_CONSTS_SVH
`define C7BEXU_CONSTS_SVH

// data and address width
`define C7B_XLEN 32

// register index width and register count
`define C7B_REG_BITS 5
`define C7B_NREGS 32

// op word, shared by the alu and branch views
`define C7B_OP_BITS 4

// link address is the next sequential instruction
`define C7B_INSN_BYTES 4

// extra cycles before the testbench declares a hang
`define C7B_TIMEOUT_MARGIN 32

`endif
